// File: hw/cpu_pkg.sv
package cpu_pkg;

  // major opcodes, instruction bits 30:25
  localparam logic [5:0] type_basic = 6'b100000;
  localparam logic [5:0] type_ls    = 6'b011100;
  localparam logic [5:0] addi_op    = 6'b101000;
  localparam logic [5:0] ori_op     = 6'b101100;
  localparam logic [5:0] xori_op    = 6'b101011;
  localparam logic [5:0] movi_op    = 6'b100010;
  localparam logic [5:0] lwi_op     = 6'b000010;
  localparam logic [5:0] swi_op     = 6'b001010;

  // type_basic sub-operations, bits 4:0
  localparam logic [4:0] add_sub   = 5'b00000;
  localparam logic [4:0] sub_sub   = 5'b00001;
  localparam logic [4:0] and_sub   = 5'b00010;
  localparam logic [4:0] or_sub    = 5'b00100;
  localparam logic [4:0] xor_sub   = 5'b00011;
  localparam logic [4:0] srli_sub  = 5'b01001;
  localparam logic [4:0] slli_sub  = 5'b01000;
  localparam logic [4:0] rotri_sub = 5'b01011;

  // type_ls sub-operations, bits 7:0
  localparam logic [7:0] lw_sub = 8'b00000010;
  localparam logic [7:0] sw_sub = 8'b00001010;

  typedef enum logic [2:0] {
    st_idle,
    st_fetch,
    st_decode,
    st_execute,
    st_memory,
    st_write
  } ctrl_state_e;

  typedef enum logic [1:0] {
    imm5_ze,
    imm15_se,
    imm15_ze,
    imm20_se
  } imm_sel_e;

  // second ALU operand
  localparam logic sel_reg = 1'b0;
  localparam logic sel_imm = 1'b1;
  // write-back source
  localparam logic sel_alu = 1'b0;
  localparam logic sel_mem = 1'b1;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  write_address;
    logic [4:0]  read_address1;
    logic [4:0]  read_address2;
    logic [1:0]  sv;
    logic [4:0]  imm5;
    logic [14:0] imm15;
    logic [19:0] imm20;
    logic [4:0]  sub5;
    logic [7:0]  sub8;
  } instr_fields_t;

  typedef struct packed {
    logic     im_read;
    logic     reg_read;
    logic     alu_execute;
    logic     dm_read;
    logic     dm_write;
    logic     reg_write;
    logic     retire;
    imm_sel_e imm_sel;
    logic     imm_reg_select;
    logic     writeback_select;
  } ctrl_t;

  // pc is the word address, zero-extended
  typedef struct packed {
    logic [31:0] pc;
    logic        wb_en;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
  } retire_t;

  // addr is the data-memory word address, zero-extended
  typedef struct packed {
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
  } store_t;

endpackage

// File: hw/word_mem.sv
`timescale 1ns/1ps

module word_mem #(
  parameter int DEPTH  = 1024,
  parameter int ADDR_W = 10
) (
  input  logic              clock,
  input  logic              we,
  input  logic [ADDR_W-1:0] addr,
  input  logic [31:0]       wdata,
  output logic [31:0]       rdata
);

  logic [31:0] mem [DEPTH];

  // read returns the old word on a write cycle
  always_ff @(posedge clock) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];
  end

endmodule

// File: hw/regfile.sv
`timescale 1ns/1ps

module regfile (
  input  logic        clock,
  input  logic        reset,
  input  logic        read_en,
  input  logic [4:0]  raddr1,
  input  logic [4:0]  raddr2,
  input  logic [4:0]  waddr,
  input  logic        we,
  input  logic [31:0] wdata,
  output logic [31:0] rdata1,
  output logic [31:0] rdata2
);

  logic [31:0] regs [32];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[waddr] <= wdata;
    end
  end

  // registered read ports
  always_ff @(posedge clock) begin
    if (read_en) begin
      rdata1 <= regs[raddr1];
      rdata2 <= regs[raddr2];
    end
  end

endmodule

// File: hw/ir_controller.sv
`timescale 1ns/1ps

module ir_controller (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   run,
  input  logic [31:0]            instr_word,
  output cpu_pkg::instr_fields_t fields,
  output cpu_pkg::ctrl_t         ctrl,
  output logic                   pc_advance
);

  cpu_pkg::ctrl_state_e state;
  cpu_pkg::ctrl_state_e state_next;
  logic [31:0] ir;
  logic        is_nop;
  logic        is_load;
  logic        is_store;
  logic        is_shift;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= cpu_pkg::st_idle;
    end else begin
      state <= state_next;
    end
  end

  // instruction register, loaded at the end of fetch
  always_ff @(posedge clock) begin
    if (reset) begin
      ir <= '0;
    end else if (ctrl.im_read) begin
      ir <= instr_word;
    end
  end

  assign fields.opcode        = ir[30:25];
  assign fields.write_address = ir[24:20];
  assign fields.read_address1 = ir[19:15];
  assign fields.read_address2 = ir[14:10];
  assign fields.sv            = ir[9:8];
  assign fields.imm5          = ir[14:10];
  assign fields.imm15         = ir[14:0];
  assign fields.imm20         = ir[19:0];
  assign fields.sub5          = ir[4:0];
  assign fields.sub8          = ir[7:0];

  assign is_shift = (fields.opcode == cpu_pkg::type_basic) &&
                    (fields.sub5 == cpu_pkg::srli_sub || fields.sub5 == cpu_pkg::slli_sub ||
                     fields.sub5 == cpu_pkg::rotri_sub);
  // NOP is SRLI by zero
  assign is_nop   = (fields.opcode == cpu_pkg::type_basic) &&
                    (fields.sub5 == cpu_pkg::srli_sub) && (fields.imm5 == 5'd0);
  assign is_load  = (fields.opcode == cpu_pkg::lwi_op) ||
                    (fields.opcode == cpu_pkg::type_ls && fields.sub8 == cpu_pkg::lw_sub);
  assign is_store = (fields.opcode == cpu_pkg::swi_op) ||
                    (fields.opcode == cpu_pkg::type_ls && fields.sub8 == cpu_pkg::sw_sub);

  always_comb begin
    case (state)
      cpu_pkg::st_idle:    state_next = run ? cpu_pkg::st_fetch : cpu_pkg::st_idle;
      cpu_pkg::st_fetch:   state_next = cpu_pkg::st_decode;
      cpu_pkg::st_decode:  state_next = cpu_pkg::st_execute;
      cpu_pkg::st_execute: state_next = (is_load || is_store) ? cpu_pkg::st_memory
                                                              : cpu_pkg::st_write;
      cpu_pkg::st_memory:  state_next = cpu_pkg::st_write;
      cpu_pkg::st_write:   state_next = run ? cpu_pkg::st_fetch : cpu_pkg::st_idle;
      default:             state_next = cpu_pkg::st_idle;
    endcase
  end

  always_comb begin
    ctrl = '0;
    ctrl.im_read     = (state == cpu_pkg::st_fetch);
    // stores reread port 2 with the data register during execute
    ctrl.reg_read    = (state == cpu_pkg::st_decode) ||
                       (state == cpu_pkg::st_execute && is_store);
    ctrl.alu_execute = (state == cpu_pkg::st_execute);
    ctrl.dm_read     = (state == cpu_pkg::st_memory) && is_load;
    ctrl.dm_write    = (state == cpu_pkg::st_memory) && is_store;
    ctrl.reg_write   = (state == cpu_pkg::st_write) && !is_nop && !is_store;
    ctrl.retire      = (state == cpu_pkg::st_write);
    ctrl.writeback_select = is_load ? cpu_pkg::sel_mem : cpu_pkg::sel_alu;

    ctrl.imm_sel        = cpu_pkg::imm5_ze;
    ctrl.imm_reg_select = cpu_pkg::sel_reg;
    case (fields.opcode)
      cpu_pkg::type_basic: begin
        if (is_shift) begin
          ctrl.imm_reg_select = cpu_pkg::sel_imm;
        end
      end
      cpu_pkg::addi_op: begin
        ctrl.imm_sel        = cpu_pkg::imm15_se;
        ctrl.imm_reg_select = cpu_pkg::sel_imm;
      end
      cpu_pkg::ori_op, cpu_pkg::xori_op, cpu_pkg::lwi_op, cpu_pkg::swi_op: begin
        ctrl.imm_sel        = cpu_pkg::imm15_ze;
        ctrl.imm_reg_select = cpu_pkg::sel_imm;
      end
      cpu_pkg::movi_op: begin
        ctrl.imm_sel        = cpu_pkg::imm20_se;
        ctrl.imm_reg_select = cpu_pkg::sel_imm;
      end
      default: ;
    endcase
  end

  // pc moves on as the instruction leaves write
  assign pc_advance = (state == cpu_pkg::st_write);

endmodule

// File: hw/alu.sv
`timescale 1ns/1ps

module alu #(
  parameter int DM_ADDR_W = 8
) (
  input  logic                   clock,
  input  logic                   reset,
  input  cpu_pkg::instr_fields_t fields,
  input  cpu_pkg::ctrl_t         ctrl,
  input  logic [31:0]            rs1_data,
  input  logic [31:0]            rs2_data,
  output logic [31:0]            alu_result,
  output logic [DM_ADDR_W-1:0]   mem_addr,
  output logic [31:0]            mem_wdata
);

  logic [31:0] imm_ext;
  logic [31:0] op_b;
  logic [31:0] result_next;
  logic [63:0] rot_pair;

  always_comb begin
    case (ctrl.imm_sel)
      cpu_pkg::imm5_ze:  imm_ext = {27'd0, fields.imm5};
      cpu_pkg::imm15_se: imm_ext = {{17{fields.imm15[14]}}, fields.imm15};
      cpu_pkg::imm15_ze: imm_ext = {17'd0, fields.imm15};
      default:           imm_ext = {{12{fields.imm20[19]}}, fields.imm20};
    endcase
  end

  assign op_b = (ctrl.imm_reg_select == cpu_pkg::sel_imm) ? imm_ext : rs2_data;

  // rotate via a doubled word
  assign rot_pair = {rs1_data, rs1_data} >> op_b[4:0];

  always_comb begin
    case (fields.opcode)
      cpu_pkg::type_basic: begin
        case (fields.sub5)
          cpu_pkg::add_sub:   result_next = rs1_data + op_b;
          cpu_pkg::sub_sub:   result_next = rs1_data - op_b;
          cpu_pkg::and_sub:   result_next = rs1_data & op_b;
          cpu_pkg::or_sub:    result_next = rs1_data | op_b;
          cpu_pkg::xor_sub:   result_next = rs1_data ^ op_b;
          cpu_pkg::srli_sub:  result_next = rs1_data >> op_b[4:0];
          cpu_pkg::slli_sub:  result_next = rs1_data << op_b[4:0];
          cpu_pkg::rotri_sub: result_next = rot_pair[31:0];
          default:            result_next = rs1_data;
        endcase
      end
      cpu_pkg::ori_op:  result_next = rs1_data | op_b;
      cpu_pkg::xori_op: result_next = rs1_data ^ op_b;
      cpu_pkg::movi_op: result_next = op_b;
      // register-indexed address, index scaled by sv
      cpu_pkg::type_ls: result_next = rs1_data + (op_b << fields.sv);
      default:          result_next = rs1_data + op_b;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      alu_result <= '0;
    end else if (ctrl.alu_execute) begin
      alu_result <= result_next;
    end
  end

  // byte address down to a word address
  assign mem_addr  = alu_result[DM_ADDR_W+1:2];
  // port 2 holds the store register by the memory cycle
  assign mem_wdata = rs2_data;

endmodule

// File: hw/writeback.sv
`timescale 1ns/1ps

module writeback #(
  parameter int IM_ADDR_W = 10
) (
  input  logic                   clock,
  input  logic                   reset,
  input  cpu_pkg::ctrl_t         ctrl,
  input  cpu_pkg::instr_fields_t fields,
  input  logic [31:0]            alu_result,
  input  logic [31:0]            dm_rdata,
  input  logic [IM_ADDR_W-1:0]   pc,
  output logic                   reg_we,
  output logic [4:0]             reg_waddr,
  output logic [31:0]            reg_wdata,
  output cpu_pkg::retire_t       retire_out,
  output logic                   retire
);

  assign reg_wdata = (ctrl.writeback_select == cpu_pkg::sel_mem) ? dm_rdata : alu_result;
  assign reg_we    = ctrl.reg_write;
  assign reg_waddr = fields.write_address;

  // trace captures the same value the register file takes
  always_ff @(posedge clock) begin
    if (reset) begin
      retire     <= 1'b0;
      retire_out <= '0;
    end else begin
      retire <= ctrl.retire;
      if (ctrl.retire) begin
        retire_out.pc      <= 32'(pc);
        retire_out.wb_en   <= reg_we;
        retire_out.wb_addr <= reg_waddr;
        retire_out.wb_data <= reg_wdata;
      end
    end
  end

endmodule

// File: hw/cpu_core_top.sv
`timescale 1ns/1ps

module cpu_core_top #(
  parameter int IM_ADDR_W = 10,
  parameter int DM_ADDR_W = 8
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 run,
  input  logic                 load_en,
  input  logic [IM_ADDR_W-1:0] load_addr,
  input  logic [31:0]          load_data,
  output cpu_pkg::retire_t     retire_out,
  output logic                 retire,
  output cpu_pkg::store_t      store_out
);

  cpu_pkg::instr_fields_t fields;
  cpu_pkg::ctrl_t         ctrl;

  logic [IM_ADDR_W-1:0] pc;
  logic [IM_ADDR_W-1:0] pc_next;
  logic [IM_ADDR_W-1:0] im_addr;
  logic [31:0]          im_rdata;
  logic                 pc_advance;
  logic [4:0]           raddr2;
  logic [31:0]          rs1_data;
  logic [31:0]          rs2_data;
  logic [31:0]          alu_result;
  logic [DM_ADDR_W-1:0] mem_addr;
  logic [DM_ADDR_W-1:0] dm_addr;
  logic [31:0]          mem_wdata;
  logic [31:0]          dm_rdata;
  logic                 reg_we;
  logic [4:0]           reg_waddr;
  logic [31:0]          reg_wdata;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= '0;
    end else if (pc_advance) begin
      pc <= pc + 1'b1;
    end
  end

  // fetch looks one word ahead as write ends
  assign pc_next = pc_advance ? pc + 1'b1 : pc;
  assign im_addr = run ? pc_next : load_addr;

  word_mem #(
    .DEPTH  (1 << IM_ADDR_W),
    .ADDR_W (IM_ADDR_W)
  ) u_imem (
    .clock (clock),
    .we    (load_en && !run),
    .addr  (im_addr),
    .wdata (load_data),
    .rdata (im_rdata)
  );

  ir_controller u_ir_controller (
    .clock      (clock),
    .reset      (reset),
    .run        (run),
    .instr_word (im_rdata),
    .fields     (fields),
    .ctrl       (ctrl),
    .pc_advance (pc_advance)
  );

  // second read of a store fetches its data register
  assign raddr2 = ctrl.alu_execute ? fields.write_address : fields.read_address2;

  regfile u_regfile (
    .clock   (clock),
    .reset   (reset),
    .read_en (ctrl.reg_read),
    .raddr1  (fields.read_address1),
    .raddr2  (raddr2),
    .waddr   (reg_waddr),
    .we      (reg_we),
    .wdata   (reg_wdata),
    .rdata1  (rs1_data),
    .rdata2  (rs2_data)
  );

  alu #(.DM_ADDR_W(DM_ADDR_W)) u_alu (
    .clock      (clock),
    .reset      (reset),
    .fields     (fields),
    .ctrl       (ctrl),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .alu_result (alu_result),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata)
  );

  // address held at zero outside memory cycles
  assign dm_addr = (ctrl.dm_read || ctrl.dm_write) ? mem_addr : '0;

  word_mem #(
    .DEPTH  (1 << DM_ADDR_W),
    .ADDR_W (DM_ADDR_W)
  ) u_dmem (
    .clock (clock),
    .we    (ctrl.dm_write),
    .addr  (dm_addr),
    .wdata (mem_wdata),
    .rdata (dm_rdata)
  );

  writeback #(.IM_ADDR_W(IM_ADDR_W)) u_writeback (
    .clock      (clock),
    .reset      (reset),
    .ctrl       (ctrl),
    .fields     (fields),
    .alu_result (alu_result),
    .dm_rdata   (dm_rdata),
    .pc         (pc),
    .reg_we     (reg_we),
    .reg_waddr  (reg_waddr),
    .reg_wdata  (reg_wdata),
    .retire_out (retire_out),
    .retire     (retire)
  );

  assign store_out.we    = ctrl.dm_write;
  assign store_out.addr  = 32'(dm_addr);
  assign store_out.wdata = mem_wdata;

endmodule

// File: bench/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;

  localparam int IM_ADDR_W = 10;
  localparam int DM_ADDR_W = 8;
  localparam int MAX_WORDS = 512;
  localparam int REC_WORDS = 7;
  localparam int TIMEOUT   = 20;

  logic                 clock = 1'b0;
  logic                 reset;
  logic                 run;
  logic                 load_en;
  logic [IM_ADDR_W-1:0] load_addr;
  logic [31:0]          load_data;
  cpu_pkg::retire_t     retire_out;
  logic                 retire;
  cpu_pkg::store_t      store_out;

  logic [31:0] test_data [MAX_WORDS];
  int          n;
  int          cycle;
  int          prev_cycle;
  int          mismatches;
  int          failures;
  int          store_count;
  logic [31:0] store_addr_seen;
  logic [31:0] store_wdata_seen;
  logic        idle_check;
  logic        timed_out;

  cpu_core_top #(
    .IM_ADDR_W (IM_ADDR_W),
    .DM_ADDR_W (DM_ADDR_W)
  ) u_cpu_core_top (
    .clock      (clock),
    .reset      (reset),
    .run        (run),
    .load_en    (load_en),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .retire_out (retire_out),
    .retire     (retire),
    .store_out  (store_out)
  );

  always #2 clock = ~clock;

  always @(posedge clock) begin
    cycle <= cycle + 1;
  end

  // outputs are sampled mid-cycle
  always @(negedge clock) begin
    if (idle_check && (retire !== 1'b0 || store_out.we !== 1'b0)) begin
      failures++;
      $display("retire or store active at %0d ns before the core was started", $time);
    end
    if (store_out.we === 1'b1) begin
      store_count++;
      store_addr_seen  = store_out.addr;
      store_wdata_seen = store_out.wdata;
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
    mismatches++;
    $display("MISMATCH at %0d ns: %s got %h expected %h", $time, name, got, expected);
  endtask

  task automatic load_program(input int count);
    for (int i = 0; i < count; i++) begin
      @(posedge clock);
      load_en   <= 1'b1;
      load_addr <= IM_ADDR_W'(i);
      load_data <= test_data[1 + i];
    end
    @(posedge clock);
    load_en <= 1'b0;
  endtask

  task automatic wait_retire(output logic got);
    int waited;
    got    = 1'b0;
    waited = 0;
    while (!got && waited < TIMEOUT) begin
      @(negedge clock);
      if (retire === 1'b1) begin
        got = 1'b1;
      end
      waited++;
    end
  endtask

  task automatic check_retire(input int k, input int count);
    int          base;
    int          latency;
    logic [31:0] word;
    logic [5:0]  op;
    base = 1 + count + REC_WORDS * k;
    word = test_data[1 + k];
    op   = word[30:25];
    // memory instructions spend one extra cycle in the memory state
    if (op == cpu_pkg::lwi_op || op == cpu_pkg::swi_op || op == cpu_pkg::type_ls) begin
      latency = 5;
    end else begin
      latency = 4;
    end
    if (cycle - prev_cycle != latency) begin
      report_mismatch("retire interval", 32'(cycle - prev_cycle), 32'(latency));
    end
    prev_cycle = cycle;
    if (retire_out.pc !== test_data[base]) begin
      report_mismatch("retire_out.pc", retire_out.pc, test_data[base]);
    end
    if (retire_out.wb_en !== test_data[base + 1][0]) begin
      report_mismatch("retire_out.wb_en", {31'd0, retire_out.wb_en}, test_data[base + 1]);
    end
    if (test_data[base + 1][0] == 1'b1) begin
      if (retire_out.wb_addr !== test_data[base + 2][4:0]) begin
        report_mismatch("retire_out.wb_addr", {27'd0, retire_out.wb_addr}, test_data[base + 2]);
      end
      if (retire_out.wb_data !== test_data[base + 3]) begin
        report_mismatch("retire_out.wb_data", retire_out.wb_data, test_data[base + 3]);
      end
    end
    // a store is one strobe cycle
    if (32'(store_count) != test_data[base + 4]) begin
      report_mismatch("store_out.we cycles", 32'(store_count), test_data[base + 4]);
    end
    if (test_data[base + 4][0] == 1'b1) begin
      if (store_addr_seen !== test_data[base + 5]) begin
        report_mismatch("store_out.addr", store_addr_seen, test_data[base + 5]);
      end
      if (store_wdata_seen !== test_data[base + 6]) begin
        report_mismatch("store_out.wdata", store_wdata_seen, test_data[base + 6]);
      end
    end
    store_count = 0;
  endtask

  task automatic run_program(input int count);
    logic got;
    int   k;
    k = 0;
    while (k < count && !timed_out) begin
      wait_retire(got);
      if (got) begin
        check_retire(k, count);
      end else begin
        failures++;
        timed_out = 1'b1;
        $display("no retire within %0d cycles for instruction %0d", TIMEOUT, k);
      end
      k++;
    end
  endtask

  task automatic finish_run();
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  endtask

  initial begin
    reset            = 1'b1;
    run              = 1'b0;
    load_en          = 1'b0;
    load_addr        = '0;
    load_data        = '0;
    prev_cycle       = 0;
    mismatches       = 0;
    failures         = 0;
    store_count      = 0;
    store_addr_seen  = '0;
    store_wdata_seen = '0;
    idle_check       = 1'b1;
    timed_out        = 1'b0;
    $readmemh("bench/cpu_tests.mem", test_data);
    n = test_data[0];
    repeat (10) @(posedge clock);
    reset <= 1'b0;
    if (n < 1 || 1 + (1 + REC_WORDS) * n > MAX_WORDS) begin
      failures++;
      $display("tests file gives no usable instruction count");
    end else begin
      load_program(n);
      // a few idle cycles with run low
      repeat (4) @(posedge clock);
      idle_check = 1'b0;
      run <= 1'b1;
      @(negedge clock);
      // fetch starts on the next edge
      prev_cycle = cycle + 1;
      run_program(n);
    end
    finish_run();
  end

endmodule

// File: sim.f
hw/cpu_pkg.sv
hw/word_mem.sv
hw/regfile.sv
hw/ir_controller.sv
hw/alu.sv
hw/writeback.sv
hw/cpu_core_top.sv
bench/tb_cpu.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_cpu \
  -Mdir obj_dir -o tb_cpu_sim

./obj_dir/tb_cpu_sim | tee sim.log

if grep -q "Regression failed" sim.log; then
  exit 1
fi
exit 0

// File: bench/cpu_tests.mem
// instruction count, then the program words
// then one record per line: pc wb_en wb_addr wb_data store_we store_addr store_wdata
00000015
44112345 44280010 40308800 40408801
40519002 40608804 40719003 5080FFFD
58914001 56A17FFF 40B11009 40C0A008
40D0900B 40110009 44E00020 44F00003
14370010 38773E0A 05070010 39173E02
4120C400
00000000 1 01 00012345 0 00000000 00000000
00000001 1 02 FFF80010 0 00000000 00000000
00000002 1 03 FFF92355 0 00000000 00000000
00000003 1 04 00092335 0 00000000 00000000
00000004 1 05 00092315 0 00000000 00000000
00000005 1 06 FFF92355 0 00000000 00000000
00000006 1 07 FFF00060 0 00000000 00000000
00000007 1 08 00012342 0 00000000 00000000
00000008 1 09 FFF84011 0 00000000 00000000
00000009 1 0A FFF87FEF 0 00000000 00000000
0000000A 1 0B 0FFF8001 0 00000000 00000000
0000000B 1 0C 01234500 0 00000000 00000000
0000000C 1 0D 50001234 0 00000000 00000000
0000000D 0 00 00000000 0 00000000 00000000
0000000E 1 0E 00000020 0 00000000 00000000
0000000F 1 0F 00000003 0 00000000 00000000
00000010 0 00 00000000 1 0000000C FFF92355
00000011 0 00 00000000 1 0000000B FFF00060
00000012 1 10 FFF92355 0 00000000 00000000
00000013 1 11 FFF00060 0 00000000 00000000
00000014 1 12 FFF123A5 0 00000000 00000000
